// File: Makefile
# Verilator build and run of the L0 buffer testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module tb_l0_buffer -f vlog.f -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	@grep -q "Test OK" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/l0_buffer_asserts.sv
// Checks on the ECRST/BCRST line code and on the sequencer ready output.
// Bound twice, each binding ties off the lines its target does not drive.
`timescale 1ns/1ps

module l0_buffer_asserts (
   input logic clk_pll_200,
   input logic reset,
   input logic ecrst,
   input logic bcrst,
   input logic ready
);

   int fail_count = 0;   // Failed assertions so far

   // ==================================================
   // Burst line code
   // ==================================================
   // SOB raises both lines, EOB only ecrst
   bcrst_with_ecrst: assert property (@(posedge clk_pll_200) disable iff (reset)
      bcrst |-> ecrst)
      else begin
         fail_count++;
         $error("bcrst high while ecrst low");
      end

   ecrst_single_cycle: assert property (@(posedge clk_pll_200) disable iff (reset)
      ecrst |=> !ecrst)
      else begin
         fail_count++;
         $error("ecrst pulse longer than one cycle");
      end

   // ready holds until the next reset
   ready_held: assert property (@(posedge clk_pll_200)
      (ready && !reset) |=> ready)
      else begin
         fail_count++;
         $error("ready fell with reset low");
      end

endmodule

bind burst_dispatcher l0_buffer_asserts u_dispatcher_asserts (
   .clk_pll_200 (clk_pll_200),
   .reset       (reset),
   .ecrst       (ecrst),
   .bcrst       (bcrst),
   .ready       (1'b1)   // No ready here
);

bind reset_sequencer l0_buffer_asserts u_sequencer_asserts (
   .clk_pll_200 (clk_pll_200),
   .reset       (reset),
   .ecrst       (1'b0),
   .bcrst       (1'b0),
   .ready       (ready)
);

// File: dv/tb_l0_buffer.sv
// Testbench for l0_buffer_top with random traffic on both ports, burst edges and flushes.
// Expected values come from a queue model of each port and of the ECRST/BCRST code.
// Inputs change on the falling edge, outputs are checked 2 ns after the rising edge.
`timescale 1ns/1ps
`include "l0_buffer_defines.svh"

module tb_l0_buffer;

   localparam int SEQ_CYCLES   = `L0_RST_HOLDOFF + `L0_RST_PULSE;
   localparam int TOTAL_CYCLES = 6 + SEQ_CYCLES + 4 + 300 + 4 * 34 + 3 * 28 + 6;

   logic                                          clk_pll_200;
   logic                                          reset;
   logic                                          burst;
   logic                                          flush;
   l0_buffer_pkg::port_vec_t                      wr_en;
   l0_buffer_pkg::port_word_t [`L0_NUM_PORTS-1:0] wr_data;
   l0_buffer_pkg::port_vec_t                      rd_en;
   l0_buffer_pkg::port_word_t [`L0_NUM_PORTS-1:0] rd_data;
   l0_buffer_pkg::port_vec_t                      empty;
   l0_buffer_pkg::port_vec_t                      full;
   l0_buffer_pkg::port_vec_t                      refill_req;
   logic                                          ecrst;
   logic                                          bcrst;
   logic                                          ready;

   // Reference model, head word at index 0
   l0_buffer_pkg::port_word_t model_q [`L0_NUM_PORTS][`L0_FIFO_DEPTH];
   int                        model_cnt [`L0_NUM_PORTS];
   l0_buffer_pkg::port_vec_t  exp_refill;
   logic                      burst_prev;   // Burst level at the last edge
   logic                      exp_ecrst;
   logic                      exp_bcrst;
   logic                      model_on;
   int                        seed;

   l0_buffer_top DUT (
      .clk_pll_200 (clk_pll_200),
      .reset       (reset),
      .burst       (burst),
      .flush       (flush),
      .wr_en       (wr_en),
      .wr_data     (wr_data),
      .rd_en       (rd_en),
      .rd_data     (rd_data),
      .empty       (empty),
      .full        (full),
      .refill_req  (refill_req),
      .ecrst       (ecrst),
      .bcrst       (bcrst),
      .ready       (ready)
   );

   initial begin
      clk_pll_200 = 1'b0;
      forever #10 clk_pll_200 = ~clk_pll_200;
   end

   task automatic abort_run();
      $display("Test FAILED");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      assert (got === exp) else begin
         $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_word(input string name, input l0_buffer_pkg::port_word_t got,
                             input l0_buffer_pkg::port_word_t exp);
      assert (got === exp) else begin
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   // One clock edge of one port, returns the expected refill_req after that edge
   function automatic logic model_step(input int p, input logic wr,
                                       input l0_buffer_pkg::port_word_t d,
                                       input logic rd, input logic clr, input logic brst);
      int   i;
      logic req;
      logic wr_ok;
      logic rd_ok;
      req   = !clr && brst && (model_cnt[p] < `L0_LOW_WATER);   // Count before the edge
      wr_ok = wr && (model_cnt[p] < `L0_FIFO_DEPTH);
      rd_ok = rd && (model_cnt[p] > 0);
      if (clr) begin
         model_cnt[p] = 0;
      end else begin
         if (rd_ok) begin
            for (i = 0; i < `L0_FIFO_DEPTH - 1; i++) begin
               model_q[p][i] = model_q[p][i+1];
            end
            model_cnt[p]--;
         end
         if (wr_ok) begin
            model_q[p][model_cnt[p]] = d;
            model_cnt[p]++;
         end
      end
      return req;
   endfunction

   // Bias arguments are chances out of 16 per cycle and port
   task automatic drive_traffic(input int cycles, input int wr_bias, input int rd_bias);
      int p;
      int r;
      repeat (cycles) begin
         @(negedge clk_pll_200);
         flush = 1'b0;
         for (p = 0; p < `L0_NUM_PORTS; p++) begin
            r          = $random(seed) & 15;
            wr_en[p]   = (r < wr_bias);
            wr_data[p] = $random(seed);
            r          = $random(seed) & 15;
            rd_en[p]   = (r < rd_bias);
         end
      end
   endtask

   // ==================================================
   // Compare process
   // ==================================================
   always @(posedge clk_pll_200) begin : compare
      int   p;
      logic clr;
      if (model_on) begin
         clr = reset | flush;
         for (p = 0; p < `L0_NUM_PORTS; p++) begin
            exp_refill[p] = model_step(p, wr_en[p], wr_data[p], rd_en[p], clr, burst);
         end
         exp_ecrst  = !clr && (burst != burst_prev);   // SOB or EOB
         exp_bcrst  = !clr && burst && !burst_prev;    // SOB only
         burst_prev = clr ? 1'b0 : burst;
         #2;
         for (p = 0; p < `L0_NUM_PORTS; p++) begin
            check_bit($sformatf("empty[%0d]", p), empty[p], model_cnt[p] == 0);
            check_bit($sformatf("full[%0d]", p), full[p], model_cnt[p] == `L0_FIFO_DEPTH);
            check_bit($sformatf("refill_req[%0d]", p), refill_req[p], exp_refill[p]);
            if (model_cnt[p] != 0) begin
               check_word($sformatf("rd_data[%0d]", p), rd_data[p], model_q[p][0]);
            end
         end
         check_bit("ecrst", ecrst, exp_ecrst);
         check_bit("bcrst", bcrst, exp_bcrst);
         check_bit("ready", ready, 1'b1);
      end
   end

   // ==================================================
   // Stimulus
   // ==================================================
   initial begin
      int n;
      int i;
      seed       = 32'h4b3b_323f;
      reset      = 1'b1;
      burst      = 1'b0;
      flush      = 1'b0;
      wr_en      = '0;
      rd_en      = '0;
      wr_data    = '0;
      model_on   = 1'b0;
      burst_prev = 1'b0;
      exp_ecrst  = 1'b0;
      exp_bcrst  = 1'b0;
      exp_refill = '0;
      for (i = 0; i < `L0_NUM_PORTS; i++) begin
         model_cnt[i] = 0;
      end
      repeat (5) @(posedge clk_pll_200);
      @(negedge clk_pll_200);
      reset = 1'b0;

      // First low-reset edge is n = 1, ready follows the hold-off and pulse
      for (n = 1; n <= SEQ_CYCLES + 4; n++) begin
         @(negedge clk_pll_200);
         check_bit("ready", ready, n > SEQ_CYCLES);
      end
      model_on = 1'b1;

      drive_traffic(150, 12, 4);   // Fill past full
      drive_traffic(150, 4, 12);   // Drain past empty

      // Burst edges, refill requests while draining inside the burst
      for (i = 0; i < 4; i++) begin
         burst = 1'b0;
         drive_traffic(10, 12, 2);
         burst = 1'b1;
         drive_traffic(24, 4, 10);
      end

      // Flush mid-traffic, with burst low and high
      for (i = 0; i < 3; i++) begin
         burst = i[0];
         drive_traffic(16, 10, 5);
         flush = 1'b1;   // One cycle, next drive clears it
         drive_traffic(12, 8, 8);
      end
      burst = 1'b0;
      drive_traffic(4, 0, 0);
      @(negedge clk_pll_200);
      if (DUT.u_burst_dispatcher.u_dispatcher_asserts.fail_count == 0 &&
          DUT.u_reset_sequencer.u_sequencer_asserts.fail_count == 0) begin
         $display("Test OK");
         $finish;
      end else begin
         $display("A bound assertion on the burst line code or on ready failed");
         abort_run();
      end
   end

   // Watchdog
   initial begin
      #(TOTAL_CYCLES * 20 + 1000);
      $display("Timeout: run did not finish within %0d cycles", TOTAL_CYCLES);
      abort_run();
   end

endmodule

// File: hw/burst_dispatcher.sv
// Start/end of burst encoder on the ECRST/BCRST pair.
// A burst level that toggles on consecutive cycles gives back-to-back codes.
`timescale 1ns/1ps

module burst_dispatcher (
   input  logic clk_pll_200,
   input  logic reset,
   input  logic soft_reset,
   input  logic flush,
   input  logic burst,
   output logic ecrst,
   output logic bcrst
);

   logic                        burst_q;   // Burst level seen on the last edge
   logic                        clear;
   l0_buffer_pkg::burst_event_e ev;

   assign clear = reset | soft_reset | flush;

   // Edge classification of the current cycle
   always_comb begin
      if (burst && !burst_q) begin
         ev = l0_buffer_pkg::EV_SOB;
      end else if (!burst && burst_q) begin
         ev = l0_buffer_pkg::EV_EOB;
      end else begin
         ev = l0_buffer_pkg::EV_NONE;
      end
   end

   // ==================================================
   // Registered line code
   // ==================================================
   always_ff @(posedge clk_pll_200) begin
      if (clear) begin
         burst_q <= 1'b0;
         ecrst   <= 1'b0;
         bcrst   <= 1'b0;
      end else begin
         burst_q <= burst;
         ecrst   <= (ev == l0_buffer_pkg::EV_SOB) || (ev == l0_buffer_pkg::EV_EOB);
         bcrst   <= (ev == l0_buffer_pkg::EV_SOB);   // Only SOB drives bcrst
      end
   end

endmodule

// File: hw/l0_buffer_defines.svh
// Sizing for the L0 primitive buffer core
// L0_FIFO_DEPTH must be a power of two so the buffer pointers wrap on their own
// L0_COUNT_W must hold the value L0_FIFO_DEPTH itself
`ifndef L0_BUFFER_DEFINES_SVH
`define L0_BUFFER_DEFINES_SVH

// ==================================================
// Buffer geometry
// ==================================================
`define L0_NUM_PORTS   2     // Buffered network ports
`define L0_DATA_W      32    // Primitive word width
`define L0_FIFO_DEPTH  16    // Words per port buffer
`define L0_COUNT_W     5     // Occupancy, 0 to depth

// Refill request fires below this many words during a burst
`define L0_LOW_WATER   4

// ==================================================
// Power-on software reset timing, in clk_pll_200 cycles
// ==================================================
`define L0_RST_HOLDOFF 32    // Settle time after external reset
`define L0_RST_PULSE   16    // Width of the software reset

`endif

// File: hw/l0_buffer_pkg.sv
// Shared types for the L0 primitive buffer core
// Widths come from the defines header
`include "l0_buffer_defines.svh"

package l0_buffer_pkg;

   // ==================================================
   // Data path types
   // ==================================================
   typedef logic [`L0_DATA_W-1:0]    port_word_t;   // One primitive word
   typedef logic [`L0_COUNT_W-1:0]   buf_count_t;   // Buffer occupancy
   typedef logic [`L0_NUM_PORTS-1:0] port_vec_t;    // One bit per port

   // Software reset sequencer states
   typedef enum logic [1:0] {
      RST_IDLE  = 2'd0,
      RST_HOLD  = 2'd1,
      RST_PULSE = 2'd2,
      RST_DONE  = 2'd3
   } rst_state_e;

   // Burst edge codes, SOB drives both lines, EOB only ecrst
   typedef enum logic [1:0] {EV_NONE = 2'd0, EV_SOB = 2'd1, EV_EOB = 2'd2} burst_event_e;

endpackage

// File: hw/l0_buffer_top.sv
// Data-path core of the L0 trigger board on a single clk_pll_200 domain.
// soft_reset from the sequencer stays internal and clears dispatcher and buffers.
// Per-port buses are packed, port 0 in the low slice.
`timescale 1ns/1ps
`include "l0_buffer_defines.svh"

module l0_buffer_top (
   input  logic                                          clk_pll_200,
   input  logic                                          reset,
   input  logic                                          burst,
   input  logic                                          flush,
   input  l0_buffer_pkg::port_vec_t                      wr_en,
   input  l0_buffer_pkg::port_word_t [`L0_NUM_PORTS-1:0] wr_data,
   input  l0_buffer_pkg::port_vec_t                      rd_en,
   output l0_buffer_pkg::port_word_t [`L0_NUM_PORTS-1:0] rd_data,
   output l0_buffer_pkg::port_vec_t                      empty,
   output l0_buffer_pkg::port_vec_t                      full,
   output l0_buffer_pkg::port_vec_t                      refill_req,
   output logic                                          ecrst,
   output logic                                          bcrst,
   output logic                                          ready
);

   logic soft_reset;   // Power-on re-init of the data path

   // ==================================================
   // Reset sequencing and burst line code
   // ==================================================
   reset_sequencer u_reset_sequencer (
      .clk_pll_200 (clk_pll_200),
      .reset       (reset),
      .soft_reset  (soft_reset),
      .ready       (ready)
   );

   burst_dispatcher u_burst_dispatcher (
      .clk_pll_200 (clk_pll_200),
      .reset       (reset),
      .soft_reset  (soft_reset),
      .flush       (flush),
      .burst       (burst),
      .ecrst       (ecrst),
      .bcrst       (bcrst)
   );

   // ==================================================
   // Per-port primitive buffers
   // ==================================================
   for (genvar p = 0; p < `L0_NUM_PORTS; p++) begin : g_port
      primitive_buffer u_buffer (
         .clk_pll_200 (clk_pll_200),
         .reset       (reset),
         .soft_reset  (soft_reset),
         .flush       (flush),
         .burst       (burst),        // Gates the refill request
         .wr_en       (wr_en[p]),
         .wr_data     (wr_data[p]),
         .rd_en       (rd_en[p]),
         .rd_data     (rd_data[p]),
         .empty       (empty[p]),
         .full        (full[p]),
         .refill_req  (refill_req[p])
      );
   end

endmodule

// File: hw/primitive_buffer.sv
// One port's primitive FIFO, filled by software and drained by the network side.
// Show-ahead read, writes while full are dropped, reads while empty ignored.
// refill_req is registered and lags the occupancy count by one cycle.
`timescale 1ns/1ps
`include "l0_buffer_defines.svh"

module primitive_buffer (
   input  logic                      clk_pll_200,
   input  logic                      reset,
   input  logic                      soft_reset,
   input  logic                      flush,
   input  logic                      burst,
   input  logic                      wr_en,
   input  l0_buffer_pkg::port_word_t wr_data,
   input  logic                      rd_en,
   output l0_buffer_pkg::port_word_t rd_data,
   output logic                      empty,
   output logic                      full,
   output logic                      refill_req
);

   localparam int PTR_W = $clog2(`L0_FIFO_DEPTH);

   l0_buffer_pkg::port_word_t  mem [`L0_FIFO_DEPTH];
   logic [PTR_W-1:0]           wr_ptr;
   logic [PTR_W-1:0]           rd_ptr;
   l0_buffer_pkg::buf_count_t  count;
   logic                       clear;
   logic                       wr_ok;
   logic                       rd_ok;

   assign clear = reset | soft_reset | flush;
   assign wr_ok = wr_en & ~full;    // Drop on full
   assign rd_ok = rd_en & ~empty;   // Ignore on empty

   // ==================================================
   // Storage, no reset on the payload
   // ==================================================
   always_ff @(posedge clk_pll_200) begin
      if (wr_ok) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk_pll_200) begin
      if (clear) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_ok) begin
            wr_ptr <= wr_ptr + PTR_W'(1);   // Wraps at depth
         end
         if (rd_ok) begin
            rd_ptr <= rd_ptr + PTR_W'(1);
         end
         case ({wr_ok, rd_ok})
            2'b10:   count <= count + l0_buffer_pkg::buf_count_t'(1);
            2'b01:   count <= count - l0_buffer_pkg::buf_count_t'(1);
            default: count <= count;   // Both or neither
         endcase
      end
   end

   // Low-watermark request, only meaningful inside a burst
   always_ff @(posedge clk_pll_200) begin
      if (clear) begin
         refill_req <= 1'b0;
      end else begin
         refill_req <= burst && (count < l0_buffer_pkg::buf_count_t'(`L0_LOW_WATER));
      end
   end

   assign rd_data = mem[rd_ptr];   // Head word, valid while not empty
   assign empty   = (count == '0);
   assign full    = (count == l0_buffer_pkg::buf_count_t'(`L0_FIFO_DEPTH));

endmodule

// File: hw/reset_sequencer.sv
// Power-on software reset: waits L0_RST_HOLDOFF edges after reset is low,
// then holds soft_reset for L0_RST_PULSE cycles and raises ready for good.
// Outputs are decoded from the state register, so they follow it by no delay.
`timescale 1ns/1ps
`include "l0_buffer_defines.svh"

module reset_sequencer (
   input  logic clk_pll_200,
   input  logic reset,
   output logic soft_reset,
   output logic ready
);

   localparam int CNT_W = $clog2(`L0_RST_HOLDOFF + `L0_RST_PULSE + 1);

   l0_buffer_pkg::rst_state_e state;
   logic [CNT_W-1:0]          cnt;   // Edges spent in the current state

   // ==================================================
   // Sequencer FSM
   // ==================================================
   always_ff @(posedge clk_pll_200) begin
      if (reset) begin
         state <= l0_buffer_pkg::RST_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            l0_buffer_pkg::RST_IDLE: begin
               // First edge with reset low counts as hold-off edge 0
               state <= l0_buffer_pkg::RST_HOLD;
               cnt   <= CNT_W'(1);
            end
            l0_buffer_pkg::RST_HOLD: begin
               if (cnt == CNT_W'(`L0_RST_HOLDOFF)) begin
                  state <= l0_buffer_pkg::RST_PULSE;
                  cnt   <= CNT_W'(1);
               end else begin
                  cnt <= cnt + CNT_W'(1);
               end
            end
            l0_buffer_pkg::RST_PULSE: begin
               if (cnt == CNT_W'(`L0_RST_PULSE)) begin
                  state <= l0_buffer_pkg::RST_DONE;   // ready rises as pulse ends
                  cnt   <= '0;
               end else begin
                  cnt <= cnt + CNT_W'(1);
               end
            end
            default: begin
               state <= l0_buffer_pkg::RST_DONE;   // Parked until next reset
               cnt   <= '0;
            end
         endcase
      end
   end

   assign soft_reset = (state == l0_buffer_pkg::RST_PULSE);
   assign ready      = (state == l0_buffer_pkg::RST_DONE);

endmodule

// File: vlog.f
+incdir+hw
hw/l0_buffer_pkg.sv
hw/reset_sequencer.sv
hw/burst_dispatcher.sv
hw/primitive_buffer.sv
hw/l0_buffer_top.sv
dv/l0_buffer_asserts.sv
dv/tb_l0_buffer.sv
